// ==== design/exec_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wasm_macros.svh"

module exec_stage import wasm_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  logic                    instr_valid,
  output logic                    instr_ready,
  input  logic [7:0]              opcode,
  input  logic [63:0]             imm,
  output stack_op_t               stack_op,
  output stack_entry_t            stack_data,
  output logic                    clear,
  input  stack_entry_t            tos,
  input  stack_entry_t            nos,
  input  logic [`STACK_CNT_W-1:0] count,
  output logic                    running,
  output trap_t                   trap
);

  stack_entry_t aux;
  stack_entry_t bin_result;
  logic [7:0]   bin_op;
  logic         phase_bin;
  logic         begin_bin;
  logic         accept;
  logic         op_is_i64;
  logic         stack_full;
  logic         tos_zero;
  value_type_t  op_type;
  trap_t        next_trap;

  // Second cycle of a binary op stalls the fetch stage
  assign instr_ready = running && !phase_bin;
  assign accept      = instr_valid && instr_ready;
  assign clear       = start;

  assign op_is_i64 = (opcode == `OP_I64_CONST) || (opcode == `OP_I64_EQZ) ||
                     (opcode == `OP_I64_EQ) || (opcode == `OP_I64_NE) ||
                     (opcode == `OP_I64_ADD) || (opcode == `OP_I64_SUB);
  assign op_type    = op_is_i64 ? VT_I64 : VT_I32;
  assign stack_full = (count == `STACK_CNT_W'(`STACK_DEPTH));
  assign tos_zero   = op_is_i64 ? (tos.value == '0) : (tos.value[31:0] == '0);

  // Binary result from the saved top and the new top, new top is the left operand
  always_comb begin
    bin_result.vtype = VT_I32;
    bin_result.value = '0;
    case (bin_op)
      `OP_I32_EQ:  bin_result.value = {63'b0, tos.value[31:0] == aux.value[31:0]};
      `OP_I32_NE:  bin_result.value = {63'b0, tos.value[31:0] != aux.value[31:0]};
      `OP_I64_EQ:  bin_result.value = {63'b0, tos.value == aux.value};
      `OP_I64_NE:  bin_result.value = {63'b0, tos.value != aux.value};
      `OP_I32_ADD: bin_result.value = {32'b0, tos.value[31:0] + aux.value[31:0]};
      `OP_I32_SUB: bin_result.value = {32'b0, tos.value[31:0] - aux.value[31:0]};
      `OP_I64_ADD: begin
        bin_result.vtype = VT_I64;
        bin_result.value = tos.value + aux.value;
      end
      `OP_I64_SUB: begin
        bin_result.vtype = VT_I64;
        bin_result.value = tos.value - aux.value;
      end
      default: begin
      end
    endcase
  end

  // All checks happen before any stack op, so a trap leaves the stack intact
  always_comb begin
    stack_op   = SOP_NONE;
    stack_data = '0;
    next_trap  = TRAP_NONE;
    begin_bin  = 1'b0;
    if (phase_bin) begin
      stack_op   = SOP_REPLACE;
      stack_data = bin_result;
    end else if (accept) begin
      case (opcode)
        `OP_UNREACHABLE: next_trap = TRAP_UNREACHABLE;
        `OP_NOP: begin
        end
        `OP_END: next_trap = TRAP_ENDED;
        `OP_DROP: begin
          if (count == '0) begin
            next_trap = TRAP_STACK_EMPTY;
          end else begin
            stack_op = SOP_POP;
          end
        end
        `OP_I32_CONST, `OP_I64_CONST: begin
          if (stack_full) begin
            next_trap = TRAP_STACK_FULL;
          end else begin
            stack_op         = SOP_PUSH;
            stack_data.vtype = op_type;
            stack_data.value = op_is_i64 ? imm : {32'b0, imm[31:0]};
          end
        end
        `OP_I32_EQZ, `OP_I64_EQZ: begin
          if (count == '0) begin
            next_trap = TRAP_STACK_EMPTY;
          end else if (tos.vtype != op_type) begin
            next_trap = TRAP_TYPE_MISMATCH;
          end else begin
            stack_op         = SOP_REPLACE;
            stack_data.vtype = VT_I32;
            stack_data.value = {63'b0, tos_zero};
          end
        end
        `OP_I32_EQ, `OP_I32_NE, `OP_I64_EQ, `OP_I64_NE,
        `OP_I32_ADD, `OP_I32_SUB, `OP_I64_ADD, `OP_I64_SUB: begin
          if (count < `STACK_CNT_W'(2)) begin
            next_trap = TRAP_STACK_EMPTY;
          end else if ((tos.vtype != op_type) || (nos.vtype != op_type)) begin
            next_trap = TRAP_TYPE_MISMATCH;
          end else begin
            stack_op  = SOP_POP;
            begin_bin = 1'b1;
          end
        end
        default: next_trap = TRAP_UNKNOWN_OPCODE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      running   <= 1'b0;
      trap      <= TRAP_NONE;
      phase_bin <= 1'b0;
    end else if (start) begin
      running   <= 1'b1;
      trap      <= TRAP_NONE;
      phase_bin <= 1'b0;
    end else begin
      phase_bin <= begin_bin;
      if (next_trap != TRAP_NONE) begin
        running <= 1'b0;
        trap    <= next_trap;
      end
    end
  end

  // Popped top kept for the replace cycle
  always_ff @(posedge clk) begin
    if (begin_bin) begin
      aux    <= tos;
      bin_op <= opcode;
    end
  end

endmodule

`default_nettype wire

// ==== design/fetch_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wasm_macros.svh"

module fetch_decode (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  logic [`WINDOW_BYTES*8-1:0] window_bytes,
  output logic [`PROG_ADDR_W-1:0]    window_addr,
  output logic                       instr_valid,
  input  logic                       instr_ready,
  output logic [7:0]                 opcode,
  output logic [63:0]                imm
);

  localparam int IMM_BYTES = `WINDOW_BYTES - 1;

  logic [`PROG_ADDR_W-1:0]    pc;
  logic [`PROG_ADDR_W-1:0]    next_pc;
  logic [`WINDOW_BYTES*8-1:0] window;
  logic                       accept;
  logic                       has_imm;
  logic                       leb_done;
  logic [3:0]                 leb_len;
  logic [3:0]                 imm_len;
  logic [63:0]                leb_val;

  assign opcode  = window[7:0];
  assign accept  = instr_valid && instr_ready;
  assign has_imm = (opcode == `OP_I32_CONST) || (opcode == `OP_I64_CONST);

  // Signed LEB128 over the bytes that follow the opcode
  always_comb begin
    leb_val  = '0;
    leb_len  = 4'(IMM_BYTES);
    leb_done = 1'b0;
    for (int i = 0; i < IMM_BYTES; i++) begin
      if (!leb_done) begin
        leb_val[7*i +: 7] = window[8*(i+1) +: 7];
        // Last byte has the continuation bit clear
        if (!window[8*(i+1)+7]) begin
          leb_done = 1'b1;
          leb_len  = 4'(i + 1);
          if (window[8*(i+1)+6]) begin
            leb_val = leb_val | ({64{1'b1}} << (7*(i+1)));
          end
        end
      end
    end
  end

  assign imm_len = has_imm ? leb_len : 4'd0;
  assign imm     = has_imm ? leb_val : 64'd0;
  assign next_pc = pc + `PROG_ADDR_W'(imm_len) + 1'b1;

  // Window follows the next PC on accept, so back to back issue needs no bubble
  always_comb begin
    if (start) begin
      window_addr = '0;
    end else if (accept) begin
      window_addr = next_pc;
    end else begin
      window_addr = pc;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= '0;
      instr_valid <= 1'b0;
    end else begin
      if (start || accept) begin
        pc <= window_addr;
      end
      if (start) begin
        instr_valid <= 1'b1;
      end
    end
  end

  // Held under back-pressure
  always_ff @(posedge clk) begin
    if (start || accept) begin
      window <= window_bytes;
    end
  end

endmodule

`default_nettype wire

// ==== design/host_apb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wasm_macros.svh"

module host_apb import wasm_pkg::*; (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [`APB_ADDR_W-1:0]           paddr,
  input  logic                             psel,
  input  logic                             penable,
  input  logic                             pwrite,
  input  logic [31:0]                      pwdata,
  output logic [31:0]                      prdata,
  output logic                             pready,
  output logic                             pslverr,
  output logic                             start,
  input  logic [`PROG_ADDR_W-1:0]          window_addr,
  output logic [`WINDOW_BYTES*8-1:0]       window_bytes,
  input  logic                             running,
  input  trap_t                            trap,
  input  logic [63:0]                      result,
  input  value_type_t                      result_type,
  input  logic                             result_empty
);

  localparam int AW = `PROG_ADDR_W;

  logic [7:0] mem [`PROG_BYTES];
  logic       access;
  logic       is_prog;

  // Zero wait states, every access ends in its access phase
  assign pready  = 1'b1;
  assign access  = psel && penable;
  assign is_prog = (paddr[`APB_ADDR_W-1:AW] == '0);

  // Program bytes are locked while the core runs
  always_ff @(posedge clk) begin
    if (access && pwrite && is_prog && !running) begin
      mem[paddr[AW-1:0]] <= pwdata[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      start <= 1'b0;
    end else begin
      start <= access && pwrite && (paddr == `REG_CTRL) && pwdata[0];
    end
  end

  always_comb begin
    prdata  = '0;
    pslverr = 1'b0;
    if (access) begin
      if (is_prog) begin
        prdata  = {24'b0, mem[paddr[AW-1:0]]};
        pslverr = pwrite && running;
      end else begin
        case (paddr)
          `REG_CTRL:      prdata = {31'b0, running};
          `REG_STATUS:    prdata = {24'b0, trap, result_type, result_empty, running};
          `REG_RESULT_LO: prdata = result[31:0];
          `REG_RESULT_HI: prdata = result[63:32];
          default:        pslverr = 1'b1;
        endcase
        // Status and result registers are read only
        if (pwrite && (paddr != `REG_CTRL)) begin
          pslverr = 1'b1;
        end
      end
    end
  end

  // Fetch window, bytes past the end of memory read as zero
  for (genvar i = 0; i < `WINDOW_BYTES; i++) begin : g_window
    logic [AW:0] pos;
    assign pos = {1'b0, window_addr} + (AW + 1)'(i);
    assign window_bytes[8*i +: 8] = pos[AW] ? 8'h00 : mem[pos[AW-1:0]];
  end

endmodule

`default_nettype wire

// ==== design/operand_stack.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wasm_macros.svh"

module operand_stack import wasm_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    clear,
  input  stack_op_t               stack_op,
  input  stack_entry_t            stack_data,
  output stack_entry_t            tos,
  output stack_entry_t            nos,
  output logic [`STACK_CNT_W-1:0] count
);

  localparam int IDX_W = `STACK_CNT_W - 1;

  stack_entry_t            entries [`STACK_DEPTH];
  logic [`STACK_CNT_W-1:0] top_pos;
  logic [`STACK_CNT_W-1:0] next_pos;
  logic [IDX_W-1:0]        push_idx;
  logic [IDX_W-1:0]        top_idx;
  logic [IDX_W-1:0]        next_idx;

  assign top_pos  = count - 1'b1;
  assign next_pos = count - 2'd2;
  assign push_idx = count[IDX_W-1:0];
  assign top_idx  = top_pos[IDX_W-1:0];
  assign next_idx = next_pos[IDX_W-1:0];

  // Empty slots read as zero
  assign tos = (count == '0) ? '0 : entries[top_idx];
  assign nos = (count < `STACK_CNT_W'(2)) ? '0 : entries[next_idx];

  always_ff @(posedge clk) begin
    if (reset || clear) begin
      count <= '0;
    end else begin
      case (stack_op)
        SOP_PUSH: count <= count + 1'b1;
        SOP_POP:  count <= count - 1'b1;
        default:  count <= count;
      endcase
    end
  end

  // No bounds check here, exec_stage only issues legal ops
  always_ff @(posedge clk) begin
    case (stack_op)
      SOP_PUSH:    entries[push_idx] <= stack_data;
      SOP_REPLACE: entries[top_idx]  <= stack_data;
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/wasm_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wasm_macros.svh"

module wasm_core import wasm_pkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`APB_ADDR_W-1:0] paddr,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [31:0]            pwdata,
  output logic [31:0]            prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic [63:0]            result,
  output value_type_t            result_type,
  output logic                   result_empty,
  output trap_t                  trap,
  output logic                   running
);

  logic                       start;
  logic                       clear;
  logic [`PROG_ADDR_W-1:0]    window_addr;
  logic [`WINDOW_BYTES*8-1:0] window_bytes;
  logic                       instr_valid;
  logic                       instr_ready;
  logic [7:0]                 opcode;
  logic [63:0]                imm;
  stack_op_t                  stack_op;
  stack_entry_t               stack_data;
  stack_entry_t               tos;
  stack_entry_t               nos;
  logic [`STACK_CNT_W-1:0]    count;

  assign result       = tos.value;
  assign result_type  = tos.vtype;
  assign result_empty = (count == '0);

  host_apb u_host (
    .clk(clk), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .start(start), .window_addr(window_addr),
    .window_bytes(window_bytes), .running(running), .trap(trap), .result(result),
    .result_type(result_type), .result_empty(result_empty)
  );

  fetch_decode u_fetch (
    .clk(clk), .reset(reset), .start(start), .window_bytes(window_bytes),
    .window_addr(window_addr), .instr_valid(instr_valid), .instr_ready(instr_ready),
    .opcode(opcode), .imm(imm)
  );

  exec_stage u_exec (
    .clk(clk), .reset(reset), .start(start), .instr_valid(instr_valid),
    .instr_ready(instr_ready), .opcode(opcode), .imm(imm), .stack_op(stack_op),
    .stack_data(stack_data), .clear(clear), .tos(tos), .nos(nos), .count(count),
    .running(running), .trap(trap)
  );

  operand_stack u_stack (
    .clk(clk), .reset(reset), .clear(clear), .stack_op(stack_op),
    .stack_data(stack_data), .tos(tos), .nos(nos), .count(count)
  );

endmodule

`default_nettype wire

// ==== design/wasm_pkg.sv ====
`default_nettype none

package wasm_pkg;

  // Value types held on the operand stack
  typedef enum logic [1:0] {
    VT_I32 = 2'd0,
    VT_I64 = 2'd1
  } value_type_t;

  // Trap causes, TRAP_NONE while the program runs normally
  typedef enum logic [3:0] {
    TRAP_NONE           = 4'd0,
    TRAP_ENDED          = 4'd1,
    TRAP_UNREACHABLE    = 4'd2,
    TRAP_UNKNOWN_OPCODE = 4'd3,
    TRAP_TYPE_MISMATCH  = 4'd4,
    TRAP_STACK_EMPTY    = 4'd5,
    TRAP_STACK_FULL     = 4'd6
  } trap_t;

  // Operations issued to the operand stack
  typedef enum logic [1:0] {
    SOP_NONE    = 2'd0,
    SOP_PUSH    = 2'd1,
    SOP_POP     = 2'd2,
    SOP_REPLACE = 2'd3
  } stack_op_t;

  // Typed stack entry
  // i32 values sit in the low word with the upper word zero
  typedef struct packed {
    value_type_t vtype;
    logic [63:0] value;
  } stack_entry_t;

endpackage

`default_nettype wire

// ==== filelist.f ====
+incdir+include
design/wasm_pkg.sv
design/host_apb.sv
design/fetch_decode.sv
design/operand_stack.sv
design/exec_stage.sv
design/wasm_core.sv
tb/wasm_core_assert.sv
tb/wasm_core_tb.sv

// ==== include/wasm_macros.svh ====
`ifndef WASM_MACROS_SVH
`define WASM_MACROS_SVH

// Opcodes of the supported instruction subset
`define OP_UNREACHABLE 8'h00
`define OP_NOP         8'h01
`define OP_END         8'h0B
`define OP_DROP        8'h1A
`define OP_I32_CONST   8'h41
`define OP_I64_CONST   8'h42
`define OP_I32_EQZ     8'h45
`define OP_I32_EQ      8'h46
`define OP_I32_NE      8'h47
`define OP_I64_EQZ     8'h50
`define OP_I64_EQ      8'h51
`define OP_I64_NE      8'h52
`define OP_I32_ADD     8'h6A
`define OP_I32_SUB     8'h6B
`define OP_I64_ADD     8'h7C
`define OP_I64_SUB     8'h7D

// Program memory and fetch window
`define PROG_ADDR_W  8
`define PROG_BYTES   (1 << `PROG_ADDR_W)
`define WINDOW_BYTES 10

// Operand stack
`define STACK_DEPTH 16
`define STACK_CNT_W 5

// APB register map, program bytes live below REG_CTRL
`define APB_ADDR_W    12
`define REG_CTRL      12'h100
`define REG_STATUS    12'h104
`define REG_RESULT_LO 12'h108
`define REG_RESULT_HI 12'h10C

`endif

// ==== run.sh ====
#!/bin/sh
# Build and run the wasm_core testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module wasm_core_tb -o sim_wasm_core
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_wasm_core +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi

exit 0

// ==== tb/wasm_core_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wasm_macros.svh"

module wasm_core_assert import wasm_pkg::*; (
  input logic                    clk,
  input logic                    reset,
  input logic                    start,
  input logic                    psel,
  input logic                    penable,
  input logic                    pready,
  input logic                    instr_valid,
  input logic                    instr_ready,
  input logic [7:0]              opcode,
  input logic [63:0]             imm,
  input logic [`STACK_CNT_W-1:0] count,
  input stack_op_t               stack_op,
  input logic                    running
);

  int unsigned fail_count = 0;

  // Zero wait state APB slave
  pready_in_access: assert property (@(posedge clk) disable iff (reset)
    (psel && penable) |-> pready)
    else begin
      fail_count++;
      $error("pready low during an APB access");
    end

  // Held instruction stays put until it is taken, a start reloads the window
  instr_held: assert property (@(posedge clk) disable iff (reset)
    (instr_valid && !instr_ready && !start) |=>
      (instr_valid && $stable(opcode) && $stable(imm)))
    else begin
      fail_count++;
      $error("instruction changed while it waited for instr_ready");
    end

  stack_bound: assert property (@(posedge clk) disable iff (reset)
    count <= `STACK_CNT_W'(`STACK_DEPTH))
    else begin
      fail_count++;
      $error("operand stack count above its depth");
    end

  idle_no_stack_op: assert property (@(posedge clk) disable iff (reset)
    !running |-> (stack_op == SOP_NONE))
    else begin
      fail_count++;
      $error("stack operation issued while the core is idle");
    end

endmodule

bind wasm_core wasm_core_assert u_assert (
  .clk(clk), .reset(reset), .start(start), .psel(psel), .penable(penable),
  .pready(pready), .instr_valid(instr_valid), .instr_ready(instr_ready),
  .opcode(opcode), .imm(imm), .count(count), .stack_op(stack_op), .running(running)
);

`default_nettype wire

// ==== tb/wasm_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wasm_macros.svh"

module wasm_core_tb import wasm_pkg::*; ();

  // Six tests of a few hundred cycles each leave a wide margin
  localparam int MAX_CYCLES = 5000;

  logic                   clk = 1'b0;
  logic                   reset;
  logic [`APB_ADDR_W-1:0] paddr;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [31:0]            pwdata;
  wire  [31:0]            prdata;
  wire                    pready;
  wire                    pslverr;
  wire  [63:0]            result;
  value_type_t            result_type;
  wire                    result_empty;
  trap_t                  trap;
  wire                    running;

  int         seed;
  int         errors;
  int         checks;
  int         tests;
  int         cycle_count = 0;
  logic [7:0] prog_buf [256];
  int         prog_len;

  wasm_core uut (
    .clk(clk), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
    .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
    .pslverr(pslverr), .result(result), .result_type(result_type),
    .result_empty(result_empty), .trap(trap), .running(running)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  initial begin
    wait (cycle_count >= MAX_CYCLES);
    $display("Timeout: run did not complete within %0d cycles", MAX_CYCLES);
    $display("Errors found");
    $finish;
  end

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  // One APB transfer entered and left 1 ns after a rising edge
  task automatic apb_access(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge clk);
    #1;
    penable = 1'b1;
    #2;
    rdata = prdata;
    err   = pslverr;
    check_value("pready in access phase", 64'(pready), 64'd1);
    @(posedge clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic reg_write(input logic [11:0] addr, input logic [31:0] data,
                           input logic exp_err);
    logic [31:0] rdata;
    logic        err;
    apb_access(1'b1, addr, data, rdata, err);
    check_value("pslverr on write", 64'(err), 64'(exp_err));
  endtask

  task automatic reg_read(input logic [11:0] addr, output logic [31:0] data,
                          input logic exp_err);
    logic err;
    apb_access(1'b0, addr, 32'd0, data, err);
    check_value("pslverr on read", 64'(err), 64'(exp_err));
  endtask

  task automatic emit_byte(input logic [7:0] b);
    prog_buf[prog_len] = b;
    prog_len++;
  endtask

  // Signed LEB128 encoder
  task automatic emit_sleb(input logic signed [63:0] value);
    logic signed [63:0] rest;
    logic [7:0]         b;
    logic               done;
    rest = value;
    done = 1'b0;
    while (!done) begin
      b    = {1'b0, rest[6:0]};
      rest = rest >>> 7;
      if ((rest == 64'sd0 && !b[6]) || (rest == -64'sd1 && b[6])) begin
        done = 1'b1;
      end else begin
        b[7] = 1'b1;
      end
      emit_byte(b);
    end
  endtask

  task automatic emit_i32(input logic [31:0] value);
    emit_byte(`OP_I32_CONST);
    emit_sleb({{32{value[31]}}, value});
  endtask

  task automatic emit_i64(input logic [63:0] value);
    emit_byte(`OP_I64_CONST);
    emit_sleb(value);
  endtask

  // Nine immediate bytes carry 63 significant bits
  task automatic random_i64(output logic [63:0] value);
    value     = {$random(seed), $random(seed)};
    value[63] = value[62];
  endtask

  task automatic load_and_start();
    for (int i = 0; i < prog_len; i++) begin
      reg_write(12'(i), {24'b0, prog_buf[i]}, 1'b0);
    end
    reg_write(`REG_CTRL, 32'd1, 1'b0);
  endtask

  // Done once the core stops with a trap code
  task automatic wait_done();
    logic [31:0] status;
    do begin
      reg_read(`REG_STATUS, status, 1'b0);
    end while (status[0] || (status[7:4] == 4'd0));
  endtask

  task automatic check_end(input trap_t exp_trap, input value_type_t exp_type,
                           input logic [63:0] exp_result, input logic exp_empty);
    check_value("trap", 64'(trap), 64'(exp_trap));
    check_value("running", 64'(running), 64'd0);
    check_value("result_empty", 64'(result_empty), 64'(exp_empty));
    if (!exp_empty) begin
      check_value("result_type", 64'(result_type), 64'(exp_type));
      check_value("result", result, exp_result);
    end
  endtask

  task automatic report_test(input string name, input int base_errors);
    tests++;
    $display("Test %s finished with %0d errors", name, errors - base_errors);
  endtask

  function automatic logic [7:0] fill_byte(input int addr);
    return 8'(addr * 37) ^ 8'h5A;
  endfunction

  task automatic test_program_memory();
    logic [31:0] data;
    int          base;
    base = errors;
    for (int i = 224; i < 256; i++) begin
      reg_write(12'(i), {24'hABCDEF, fill_byte(i)}, 1'b0);
    end
    for (int i = 224; i < 256; i++) begin
      reg_read(12'(i), data, 1'b0);
      check_value("program byte", 64'(data), 64'(fill_byte(i)));
    end
    reg_read(12'h200, data, 1'b1);
    // Long nop run keeps the core busy during the refused write
    prog_len = 0;
    for (int i = 0; i < 20; i++) begin
      emit_byte(`OP_NOP);
    end
    emit_byte(`OP_END);
    load_and_start();
    reg_write(12'h0F0, 32'h0000_00C3, 1'b1);
    wait_done();
    reg_read(12'h0F0, data, 1'b0);
    check_value("locked program byte", 64'(data), 64'(fill_byte(240)));
    check_end(TRAP_ENDED, VT_I32, 64'd0, 1'b1);
    report_test("program_memory", base);
  endtask

  task automatic test_i32_arith();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] exp;
    int          base;
    base = errors;
    a    = -32'sd300000;
    b    = 32'h7FFF_F1C0;
    c    = -32'sd5;
    exp  = (a + b) - c;
    prog_len = 0;
    emit_i32(a);
    emit_i32(b);
    emit_byte(`OP_I32_ADD);
    emit_i32(c);
    emit_byte(`OP_I32_SUB);
    emit_byte(`OP_END);
    load_and_start();
    wait_done();
    check_end(TRAP_ENDED, VT_I32, {32'b0, exp}, 1'b0);
    report_test("i32_arith", base);
  endtask

  task automatic run_compare(input logic [7:0] op, input logic [63:0] x, input logic [63:0] y,
                             input logic use_y, input logic [63:0] exp);
    logic [31:0] lo;
    logic [31:0] hi;
    prog_len = 0;
    emit_i64(x);
    if (use_y) begin
      emit_i64(y);
    end
    emit_byte(op);
    emit_byte(`OP_END);
    load_and_start();
    wait_done();
    check_end(TRAP_ENDED, VT_I32, exp, 1'b0);
    reg_read(`REG_RESULT_LO, lo, 1'b0);
    reg_read(`REG_RESULT_HI, hi, 1'b0);
    check_value("result over APB", {hi, lo}, exp);
  endtask

  task automatic test_i64_compare();
    logic [63:0] x;
    logic [63:0] y;
    int          base;
    base = errors;
    random_i64(x);
    random_i64(y);
    run_compare(`OP_I64_EQ, x, y, 1'b1, 64'(x == y));
    run_compare(`OP_I64_EQ, x, x, 1'b1, 64'd1);
    run_compare(`OP_I64_NE, x, y, 1'b1, 64'(x != y));
    run_compare(`OP_I64_NE, y, y, 1'b1, 64'd0);
    run_compare(`OP_I64_EQZ, x, 64'd0, 1'b0, 64'(x == 64'd0));
    run_compare(`OP_I64_EQZ, 64'd0, 64'd0, 1'b0, 64'd1);
    report_test("i64_compare", base);
  endtask

  task automatic test_type_mismatch();
    logic [63:0] v;
    int          base;
    base = errors;
    random_i64(v);
    prog_len = 0;
    emit_i32(32'd5);
    emit_i64(v);
    emit_byte(`OP_I32_ADD);
    emit_byte(`OP_END);
    load_and_start();
    wait_done();
    check_end(TRAP_TYPE_MISMATCH, VT_I64, v, 1'b0);
    report_test("type_mismatch", base);
  endtask

  task automatic run_single(input logic [7:0] op, input trap_t exp_trap);
    prog_len = 0;
    emit_byte(op);
    emit_byte(`OP_END);
    load_and_start();
    wait_done();
    check_end(exp_trap, VT_I32, 64'd0, 1'b1);
  endtask

  task automatic test_trap_codes();
    int base;
    base = errors;
    run_single(`OP_UNREACHABLE, TRAP_UNREACHABLE);
    run_single(8'h99, TRAP_UNKNOWN_OPCODE);
    run_single(`OP_DROP, TRAP_STACK_EMPTY);
    // Seventeenth push finds the stack full and leaves the sixteenth on top
    prog_len = 0;
    for (int i = 1; i <= 17; i++) begin
      emit_i32(32'(i));
    end
    emit_byte(`OP_END);
    load_and_start();
    wait_done();
    check_end(TRAP_STACK_FULL, VT_I32, 64'd16, 1'b0);
    report_test("trap_codes", base);
  endtask

  task automatic test_restart();
    logic [31:0] status;
    int          base;
    base = errors;
    prog_len = 0;
    for (int i = 0; i < 4; i++) begin
      emit_byte(`OP_NOP);
    end
    emit_i32(32'd7);
    emit_byte(`OP_DROP);
    emit_byte(`OP_END);
    load_and_start();
    reg_read(`REG_STATUS, status, 1'b0);
    check_value("running after start", 64'(status[0]), 64'd1);
    check_value("trap after start", 64'(status[7:4]), 64'(TRAP_NONE));
    check_value("stack cleared on start", 64'(status[1]), 64'd1);
    wait_done();
    check_end(TRAP_ENDED, VT_I32, 64'd0, 1'b1);
    report_test("restart", base);
  endtask

  initial begin
    seed    = 34312;
    errors  = 0;
    checks  = 0;
    tests   = 0;
    reset   = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    @(posedge clk);
    #1;
    test_program_memory();
    test_i32_arith();
    test_i64_compare();
    test_type_mismatch();
    test_trap_codes();
    test_restart();
    errors = errors + int'(uut.u_assert.fail_count);
    $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
